/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = filelist.f
BUILD_DIR = obj_dir
RUN_ARGS  = +verilator+error+limit+100
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_arvalid,
   output logic              o_arready,
   input  dcache_pkg::addr_t i_araddr,
   output logic              o_rvalid,
   input  logic              i_rready,
   output dcache_pkg::word_t o_rdata,
   output logic              o_rlast,
   input  logic              i_awvalid,
   output logic              o_awready,
   input  dcache_pkg::addr_t i_awaddr,
   input  logic              i_wvalid,
   output logic              o_wready,
   input  dcache_pkg::word_t i_wdata,
   input  logic              i_wlast,
   output logic              o_bvalid,
   input  logic              i_bready
);
   import dcache_pkg::*;

   // Sparse storage, written words only
   word_t mem [addr_t];

   function automatic word_t read_word(input addr_t a);
      word_t w;
      if (mem.exists(a))
         w = mem[a];
      else
         w = a ^ 32'hA5A50000;
      return w;
   endfunction

   function automatic int pick_gap();
      return int'($urandom_range(0, 3));
   endfunction

   initial
   begin
      addr_t rd_addr;
      addr_t wr_addr;
      int    rd_beat;
      int    wr_beat;
      int    ar_gap;
      int    r_gap;
      int    aw_gap;
      int    w_gap;
      int    b_gap;
      bit    rd_busy;
      bit    wr_busy;
      bit    w_done;

      void'($urandom(32'h5f6));
      o_arready = 1'b0;
      o_rvalid = 1'b0;
      o_rdata = '0;
      o_rlast = 1'b0;
      o_awready = 1'b0;
      o_wready = 1'b0;
      o_bvalid = 1'b0;
      rd_addr = '0;
      wr_addr = '0;
      rd_beat = 0;
      wr_beat = 0;
      ar_gap = pick_gap();
      r_gap = 0;
      aw_gap = pick_gap();
      w_gap = 0;
      b_gap = 0;
      rd_busy = 1'b0;
      wr_busy = 1'b0;
      w_done = 1'b0;
      forever
      begin
         @(posedge i_clk);
         if (!i_rst_n)
         begin
            o_arready <= 1'b0;
            o_rvalid <= 1'b0;
            o_rlast <= 1'b0;
            o_awready <= 1'b0;
            o_wready <= 1'b0;
            o_bvalid <= 1'b0;
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            w_done = 1'b0;
         end
         else
         begin
            // R beats with a bubble of random length between them
            if (o_rvalid && i_rready)
            begin
               o_rvalid <= 1'b0;
               rd_beat++;
               if (o_rlast)
                  rd_busy = 1'b0;
               r_gap = pick_gap();
            end
            else if (rd_busy && !o_rvalid)
            begin
               if (r_gap == 0)
               begin
                  o_rvalid <= 1'b1;
                  o_rdata <= read_word(rd_addr + addr_t'(4 * rd_beat));
                  o_rlast <= (rd_beat == LINE_WORDS - 1);
               end
               else
                  r_gap--;
            end

            if (o_arready && i_arvalid)
            begin
               o_arready <= 1'b0;
               rd_addr = i_araddr;
               rd_beat = 0;
               rd_busy = 1'b1;
               r_gap = pick_gap();
            end
            else if (i_arvalid && !rd_busy && !o_arready)
            begin
               if (ar_gap == 0)
               begin
                  o_arready <= 1'b1;
                  ar_gap = pick_gap();
               end
               else
                  ar_gap--;
            end

            if (o_bvalid && i_bready)
            begin
               o_bvalid <= 1'b0;
               wr_busy = 1'b0;
               w_done = 1'b0;
            end
            else if (w_done && !o_bvalid)
            begin
               if (b_gap == 0)
                  o_bvalid <= 1'b1;
               else
                  b_gap--;
            end

            // W data is taken only once the burst address is known
            if (o_wready && i_wvalid)
            begin
               o_wready <= 1'b0;
               mem[wr_addr + addr_t'(4 * wr_beat)] = i_wdata;
               wr_beat++;
               if (i_wlast)
               begin
                  w_done = 1'b1;
                  b_gap = pick_gap();
               end
               w_gap = pick_gap();
            end
            else if (wr_busy && !w_done && !o_wready && i_wvalid)
            begin
               if (w_gap == 0)
                  o_wready <= 1'b1;
               else
                  w_gap--;
            end

            if (o_awready && i_awvalid)
            begin
               o_awready <= 1'b0;
               wr_addr = i_awaddr;
               wr_beat = 0;
               wr_busy = 1'b1;
               w_gap = pick_gap();
            end
            else if (i_awvalid && !wr_busy && !o_awready)
            begin
               if (aw_gap == 0)
               begin
                  o_awready <= 1'b1;
                  aw_gap = pick_gap();
               end
               else
                  aw_gap--;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* bench/dcache_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_chk (
   input logic              i_clk,
   input logic              i_rst_n,
   input logic              i_arvalid,
   input logic              i_arready,
   input dcache_pkg::addr_t i_araddr,
   input logic              i_awvalid,
   input logic              i_awready,
   input dcache_pkg::addr_t i_awaddr,
   input logic              i_wvalid,
   input logic              i_wlast
);
   import dcache_pkg::*;

   int unsigned ar_hold_fails = 0;
   int unsigned aw_hold_fails = 0;
   int unsigned ar_align_fails = 0;
   int unsigned aw_align_fails = 0;
   int unsigned wlast_fails = 0;
   int unsigned fail_cnt;

   // Total of all failed assertions
   assign fail_cnt = ar_hold_fails + aw_hold_fails + ar_align_fails +
                     aw_align_fails + wlast_fails;

   a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
   else
   begin
      ar_hold_fails++;
      $error("AR valid dropped or address changed before acceptance");
   end

   a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
   else
   begin
      aw_hold_fails++;
      $error("AW valid dropped or address changed before acceptance");
   end

   a_ar_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !i_arvalid || (i_araddr[OFFS_W-1:0] == '0))
   else
   begin
      ar_align_fails++;
      $error("AR address is not line aligned");
   end

   a_aw_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !i_awvalid || (i_awaddr[OFFS_W-1:0] == '0))
   else
   begin
      aw_align_fails++;
      $error("AW address is not line aligned");
   end

   a_wlast_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !i_wlast || i_wvalid)
   else
   begin
      wlast_fails++;
      $error("WLAST seen without WVALID");
   end

endmodule

`default_nettype wire

/* bench/dcache_patterns.txt */
// op addr mask wdata expected, one operation per line
// op: 0 read, 1 write, 2 invalidate; expected is used by reads only
0 00000040 0 00000000 a5a50040
0 00000154 0 00000000 a5a50154
0 0000015c 0 00000000 a5a5015c
1 00000268 5 11223344 00000000
0 00000268 0 00000000 a5220244
1 0000026c a deadbeef 00000000
0 0000026c 0 00000000 dea5be6c
0 00000264 0 00000000 a5a50264
1 00001024 f 11111111 00000000
1 00002024 f 22222222 00000000
1 00003024 f 33333333 00000000
0 00001024 0 00000000 11111111
0 00002024 0 00000000 22222222
0 00003024 0 00000000 33333333
0 00001028 0 00000000 a5a51028
0 00002028 0 00000000 a5a52028
0 00000380 0 00000000 a5a50380
2 00000380 0 00000000 00000000
0 00000380 0 00000000 a5a50380
1 00000494 f cafef00d 00000000
0 00000494 0 00000000 cafef00d
2 00000494 0 00000000 00000000
0 00000494 0 00000000 a5a50494

/* bench/tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
   import dcache_pkg::*;

   localparam int MAX_OPS = 32;
   localparam int WAIT_LIMIT = 1000;

   logic  clk;
   logic  rst_n;
   logic  req;
   addr_t addr;
   wmask_t wmask;
   word_t wdata;
   logic  inv;
   logic  stall;
   word_t rdata;
   logic  arvalid;
   logic  arready;
   addr_t araddr;
   logic  rvalid;
   logic  rready;
   word_t axi_rdata;
   logic  rlast;
   logic  awvalid;
   logic  awready;
   addr_t awaddr;
   logic  wvalid;
   logic  wready;
   word_t axi_wdata;
   logic  wlast;
   logic  bvalid;
   logic  bready;

   // Five words per operation
   word_t pat [MAX_OPS*5];
   int    n_pass = 0;
   int    n_fail = 0;

   dcache_top #(
      .P_SETS (4),
      .P_WAYS (1)
   )
   u_dcache_top
   (
      .i_clk     (clk),
      .i_rst_n   (rst_n),
      .i_req     (req),
      .i_addr    (addr),
      .i_wmask   (wmask),
      .i_wdata   (wdata),
      .i_inv     (inv),
      .o_stall   (stall),
      .o_rdata   (rdata),
      .o_arvalid (arvalid),
      .i_arready (arready),
      .o_araddr  (araddr),
      .i_rvalid  (rvalid),
      .o_rready  (rready),
      .i_rdata   (axi_rdata),
      .i_rlast   (rlast),
      .o_awvalid (awvalid),
      .i_awready (awready),
      .o_awaddr  (awaddr),
      .o_wvalid  (wvalid),
      .i_wready  (wready),
      .o_wdata   (axi_wdata),
      .o_wlast   (wlast),
      .i_bvalid  (bvalid),
      .o_bready  (bready)
   );

   axi_mem_model u_mem
   (
      .i_clk     (clk),
      .i_rst_n   (rst_n),
      .i_arvalid (arvalid),
      .o_arready (arready),
      .i_araddr  (araddr),
      .o_rvalid  (rvalid),
      .i_rready  (rready),
      .o_rdata   (axi_rdata),
      .o_rlast   (rlast),
      .i_awvalid (awvalid),
      .o_awready (awready),
      .i_awaddr  (awaddr),
      .i_wvalid  (wvalid),
      .o_wready  (wready),
      .i_wdata   (axi_wdata),
      .i_wlast   (wlast),
      .o_bvalid  (bvalid),
      .i_bready  (bready)
   );

   bind dcache_top dcache_chk u_chk
   (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_arvalid (o_arvalid),
      .i_arready (i_arready),
      .i_araddr  (o_araddr),
      .i_awvalid (o_awvalid),
      .i_awready (i_awready),
      .i_awaddr  (o_awaddr),
      .i_wvalid  (o_wvalid),
      .i_wlast   (o_wlast)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
      begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         n_fail++;
      end
      else
      begin
         $display("ok     %s: %h", name, actual);
         n_pass++;
      end
   endtask

   // Returns at a falling edge with o_stall low
   task automatic wait_ready(input string what, output bit ok);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (stall && cycles < WAIT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      ok = !stall;
      if (!ok)
      begin
         $display("%s: the cache kept stalling for %0d cycles", what, WAIT_LIMIT);
         n_fail++;
      end
   endtask

   task automatic run_op(input int idx, output bit ok);
      word_t  op;
      addr_t  a;
      wmask_t m;
      word_t  d;
      word_t  expected;
      string  name;

      op = pat[5*idx];
      a = pat[5*idx+1];
      m = wmask_t'(pat[5*idx+2]);
      d = pat[5*idx+3];
      expected = pat[5*idx+4];
      case (op)
         32'h0: name = $sformatf("#%0d read  %h", idx, a);
         32'h1: name = $sformatf("#%0d write %h", idx, a);
         default: name = $sformatf("#%0d inval %h", idx, a);
      endcase

      @(posedge clk);
      req <= 1'b1;
      addr <= a;
      wmask <= (op == 32'h1) ? m : '0;
      wdata <= d;
      inv <= (op == 32'h2);
      wait_ready({name, " accept"}, ok);
      if (ok)
      begin
         // Accepting edge
         @(posedge clk);
         req <= 1'b0;
         inv <= 1'b0;
         wmask <= '0;
         wait_ready({name, " response"}, ok);
      end
      if (ok)
      begin
         if (op == 32'h0)
            check_value(name, expected, rdata);
         else
         begin
            $display("ok     %s", name);
            n_pass++;
         end
      end
   endtask

   initial
   begin
      int i;
      bit ok;
      int chk_fails;

      rst_n = 1'b0;
      req = 1'b0;
      addr = '0;
      wmask = '0;
      wdata = '0;
      inv = 1'b0;
      for (int k = 0; k < MAX_OPS*5; k++)
         pat[k] = 32'hFFFF_FFFF;
      $readmemh("bench/dcache_patterns.txt", pat);

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      wait_ready("boot", ok);
      if (ok)
      begin
         $display("ok     boot clear done");
         n_pass++;
      end

      i = 0;
      while (ok && i < MAX_OPS && pat[5*i] != 32'hFFFF_FFFF)
      begin
         run_op(i, ok);
         i++;
      end

      chk_fails = int'(u_dcache_top.u_chk.fail_cnt);
      if (chk_fails != 0)
         $display("bus protocol assertions failed %0d times", chk_fails);
      $display("tests: %0d passed, %0d failed, %0d assertion failures",
               n_pass, n_fail, chk_fails);
      if (n_fail == 0 && chk_fails == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* design/axi_line_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_line_master (
   input  logic              i_clk,
   input  logic              i_rst_n,
   line_xfer_if.master       xfer,
   // Read path
   output logic              o_arvalid,
   input  logic              i_arready,
   output dcache_pkg::addr_t o_araddr,
   input  logic              i_rvalid,
   output logic              o_rready,
   input  dcache_pkg::word_t i_rdata,
   input  logic              i_rlast,
   // Write path
   output logic              o_awvalid,
   input  logic              i_awready,
   output dcache_pkg::addr_t o_awaddr,
   output logic              o_wvalid,
   input  logic              i_wready,
   output dcache_pkg::word_t o_wdata,
   output logic              o_wlast,
   input  logic              i_bvalid,
   output logic              o_bready
);
   import dcache_pkg::*;

   beat_t wcnt;
   logic  r_hs;
   logic  w_hs;
   logic  b_hs;

   assign r_hs = i_rvalid && o_rready;
   assign w_hs = o_wvalid && i_wready;
   assign b_hs = i_bvalid && o_bready;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         o_arvalid <= 1'b0;
         o_rready <= 1'b0;
      end
      else
      begin
         if (xfer.rd_start)
            o_arvalid <= 1'b1;
         else if (o_arvalid && i_arready)
            o_arvalid <= 1'b0;
         // Accept R beats until the last one of the burst
         if (xfer.rd_start)
            o_rready <= 1'b1;
         else if (r_hs && i_rlast)
            o_rready <= 1'b0;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         o_awvalid <= 1'b0;
         o_wvalid <= 1'b0;
         o_bready <= 1'b0;
         wcnt <= '0;
      end
      else
      begin
         if (xfer.wr_start)
            o_awvalid <= 1'b1;
         else if (o_awvalid && i_awready)
            o_awvalid <= 1'b0;
         // W beats may run ahead of the AW handshake
         if (xfer.wr_start)
         begin
            o_wvalid <= 1'b1;
            wcnt <= '0;
         end
         else if (w_hs)
         begin
            wcnt <= wcnt + 1'b1;
            if (o_wlast)
               o_wvalid <= 1'b0;
         end
         if (xfer.wr_start)
            o_bready <= 1'b1;
         else if (b_hs)
            o_bready <= 1'b0;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (xfer.rd_start)
         o_araddr <= xfer.line_addr;
      if (xfer.wr_start)
         o_awaddr <= xfer.line_addr;
   end

   assign o_wlast = (wcnt == beat_t'(LINE_WORDS - 1));
   assign o_wdata = xfer.wbeat_data;

   assign xfer.rbeat_valid = r_hs;
   assign xfer.rbeat_data = i_rdata;
   assign xfer.wbeat_take = w_hs;
   assign xfer.done = (r_hs && i_rlast) || b_hs;

endmodule

`default_nettype wire

/* design/cache_ways.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ways #(
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
)
(
   input  logic    i_clk,
   input  logic    i_rst_n,
   way_port_if.ways port
);
   import dcache_pkg::*;

   localparam int NWAYS = 1 << P_WAYS;
   localparam int NSETS = 1 << P_SETS;
   localparam int TAG_W = ADDR_W - P_SETS - OFFS_W;

   logic [P_SETS-1:0] wr_idx;
   logic [NWAYS-1:0]  victim_ptr;
   logic [NWAYS-1:0]  victim_q;
   logic [NWAYS-1:0]  hit_raw;
   logic [NWAYS-1:0]  dirty_vec;
   logic [TAG_W-1:0]  tag_vec [NWAYS];
   word_t             data_vec [NWAYS];
   logic [NWAYS-1:0]  sel;
   word_t             rdata;
   logic              vdirty;
   logic [TAG_W-1:0]  vtag;
   logic              same_set;
   logic              same_word;

   // Writes go to the set of the last lookup
   assign same_set = (port.index == wr_idx);
   assign same_word = same_set && (port.rd_offs == port.wr_offs);

   always_ff @(posedge i_clk)
   begin
      if (port.rd_en)
      begin
         wr_idx <= port.index;
         victim_q <= victim_ptr;
      end
   end

   // Clock pointer, one step per cycle
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
         victim_ptr <= NWAYS'(1);
      else
         victim_ptr <= (victim_ptr << 1) | (victim_ptr >> (NWAYS - 1));
   end

   for (genvar w = 0; w < NWAYS; w++)
   begin : g_way
      logic [TAG_W-1:0] tag_ram [NSETS];
      logic [NSETS-1:0] valid_ram;
      logic [NSETS-1:0] dirty_ram;
      word_t            data_ram [NSETS*LINE_WORDS];
      logic [TAG_W-1:0] tag_rd;
      logic             valid_rd;
      logic             dirty_rd;
      word_t            data_rd;
      logic             tag_fwd;
      logic             dirty_fwd;

      assign tag_fwd = port.tag_we && port.wr_way[w] && same_set;
      assign dirty_fwd = port.dirty_we && port.wr_way[w] && same_set;

      always_ff @(posedge i_clk)
      begin
         if (port.valid_clr)
         begin
            valid_ram[port.index] <= 1'b0;
            dirty_ram[port.index] <= 1'b0;
         end
         if (port.tag_we && port.wr_way[w])
         begin
            tag_ram[wr_idx] <= port.lookup_tag;
            valid_ram[wr_idx] <= 1'b1;
         end
         if (port.dirty_we && port.wr_way[w])
            dirty_ram[wr_idx] <= port.dirty_val;
         for (int b = 0; b < WORD_W / 8; b++)
         begin
            if (port.wr_way[w] && port.wr_mask[b])
               data_ram[{wr_idx, port.wr_offs}][8*b +: 8] <= port.wr_data[8*b +: 8];
         end
      end

      // Write-first read port
      always_ff @(posedge i_clk)
      begin
         if (port.rd_en)
         begin
            tag_rd <= tag_fwd ? port.lookup_tag : tag_ram[port.index];
            valid_rd <= !port.valid_clr && (tag_fwd || valid_ram[port.index]);
            dirty_rd <= !port.valid_clr &&
                        (dirty_fwd ? port.dirty_val : dirty_ram[port.index]);
            for (int b = 0; b < WORD_W / 8; b++)
            begin
               if (port.wr_way[w] && port.wr_mask[b] && same_word)
                  data_rd[8*b +: 8] <= port.wr_data[8*b +: 8];
               else
                  data_rd[8*b +: 8] <= data_ram[{port.index, port.rd_offs}][8*b +: 8];
            end
         end
      end

      assign hit_raw[w] = valid_rd && (tag_rd == port.lookup_tag);
      assign dirty_vec[w] = dirty_rd;
      assign tag_vec[w] = tag_rd;
      assign data_vec[w] = data_rd;
   end

   always_comb
   begin
      sel = (|hit_raw) ? hit_raw : victim_q;
      rdata = '0;
      vdirty = 1'b0;
      vtag = '0;
      for (int w = 0; w < NWAYS; w++)
      begin
         if (sel[w])
            rdata = rdata | data_vec[w];
         if (victim_q[w])
         begin
            vdirty = vdirty | dirty_vec[w];
            vtag = vtag | tag_vec[w];
         end
      end
   end

   assign port.hit_vec = hit_raw;
   assign port.rdata = rdata;
   assign port.victim_way = victim_q;
   assign port.victim_dirty = vdirty;
   assign port.victim_tag = vtag;

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
)
(
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_req,
   input  dcache_pkg::addr_t  i_addr,
   input  dcache_pkg::wmask_t i_wmask,
   input  dcache_pkg::word_t  i_wdata,
   input  logic               i_inv,
   output logic               o_stall,
   output dcache_pkg::word_t  o_rdata,
   way_port_if.ctrl           ways,
   line_xfer_if.ctrl          xfer
);
   import dcache_pkg::*;

   localparam int NWAYS = 1 << P_WAYS;
   localparam int TAG_W = ADDR_W - P_SETS - OFFS_W;
   localparam int BEAT_W = $bits(beat_t);

   ctrl_state_e       state;
   ctrl_state_e       state_nxt;
   logic              req_v;
   addr_t             req_addr;
   wmask_t            req_wmask;
   word_t             req_wdata;
   logic              req_inv;
   logic [P_SETS-1:0] boot_cnt;
   beat_t             beat_cnt;
   logic [NWAYS-1:0]  vic_way;
   logic [TAG_W-1:0]  req_tag;
   logic [P_SETS-1:0] req_idx;
   beat_t             req_offs;
   logic              hit;
   logic              hit_wr;
   logic              wb_start;
   logic              rf_start;

   assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
   assign req_idx = req_addr[OFFS_W +: P_SETS];
   assign req_offs = req_addr[OFFS_W-BEAT_W +: BEAT_W];

   assign hit = |ways.hit_vec;
   assign o_stall = (state != IDLE) || (req_v && (req_inv || !hit));
   assign hit_wr = (state == IDLE) && req_v && !req_inv && hit && (|req_wmask);
   assign o_rdata = ways.rdata;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
         req_v <= 1'b0;
      else if (!o_stall)
         req_v <= i_req;
      else if (state == INVALIDATE)
         req_v <= 1'b0;
   end

   always_ff @(posedge i_clk)
   begin
      if (!o_stall)
      begin
         req_addr <= i_addr;
         req_wmask <= i_wmask;
         req_wdata <= i_wdata;
         req_inv <= i_inv;
      end
      if (state == REPLACE)
         vic_way <= ways.victim_way;
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         state <= BOOT;
         boot_cnt <= '0;
         beat_cnt <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state == BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         // Writeback reads run one word ahead of the W channel
         if (state == REPLACE)
            beat_cnt <= ways.victim_dirty ? beat_t'(1) : beat_t'(0);
         else if ((state == WRITEBACK) && xfer.done)
            beat_cnt <= '0;
         else if (((state == WRITEBACK) && xfer.wbeat_take) ||
                  ((state == REFILL) && xfer.rbeat_valid))
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         BOOT:
            if (&boot_cnt)
               state_nxt = IDLE;
         IDLE:
            if (req_v && req_inv)
               state_nxt = INVALIDATE;
            else if (req_v && !hit)
               state_nxt = REPLACE;
         REPLACE:
            state_nxt = ways.victim_dirty ? WRITEBACK : REFILL;
         WRITEBACK:
            if (xfer.done)
               state_nxt = REFILL;
         REFILL:
            if (xfer.done)
               state_nxt = RELOAD;
         RELOAD,
         INVALIDATE:
            state_nxt = IDLE;
         default:
            state_nxt = BOOT;
      endcase
   end

   assign wb_start = (state == REPLACE) && ways.victim_dirty;
   assign rf_start = ((state == REPLACE) && !ways.victim_dirty) ||
                     ((state == WRITEBACK) && xfer.done);

   assign xfer.wr_start = wb_start;
   assign xfer.rd_start = rf_start;
   assign xfer.line_addr = wb_start ? {ways.victim_tag, req_idx, {OFFS_W{1'b0}}}
                                    : {req_tag, req_idx, {OFFS_W{1'b0}}};
   assign xfer.wbeat_data = ways.rdata;

   assign ways.lookup_tag = req_tag;

   always_comb
   begin
      ways.index = req_idx;
      ways.rd_en = 1'b0;
      ways.rd_offs = req_offs;
      ways.wr_way = '0;
      ways.wr_offs = req_offs;
      ways.wr_mask = '0;
      ways.wr_data = req_wdata;
      ways.tag_we = 1'b0;
      ways.valid_clr = 1'b0;
      ways.dirty_we = 1'b0;
      ways.dirty_val = 1'b1;
      case (state)
         BOOT:
         begin
            ways.index = boot_cnt;
            ways.valid_clr = 1'b1;
         end
         IDLE:
         begin
            // Lookup of the incoming request beside the write of the held one
            ways.index = i_addr[OFFS_W +: P_SETS];
            ways.rd_offs = i_addr[OFFS_W-BEAT_W +: BEAT_W];
            ways.rd_en = i_req && !o_stall;
            if (hit_wr)
            begin
               ways.wr_way = ways.hit_vec;
               ways.wr_mask = req_wmask;
               ways.dirty_we = 1'b1;
            end
         end
         REPLACE:
         begin
            ways.rd_en = ways.victim_dirty;
            ways.rd_offs = '0;
            ways.wr_way = ways.victim_way;
            ways.tag_we = 1'b1;
            ways.dirty_we = 1'b1;
            ways.dirty_val = 1'b0;
         end
         WRITEBACK:
         begin
            ways.rd_en = xfer.wbeat_take;
            ways.rd_offs = beat_cnt;
         end
         REFILL:
         begin
            ways.wr_way = vic_way;
            ways.wr_offs = beat_cnt;
            ways.wr_mask = xfer.rbeat_valid ? '1 : '0;
            ways.wr_data = xfer.rbeat_data;
         end
         RELOAD:
         begin
            ways.rd_en = 1'b1;
            ways.wr_way = vic_way;
            ways.wr_mask = req_wmask;
            ways.dirty_we = |req_wmask;
         end
         INVALIDATE:
            ways.valid_clr = 1'b1;
         default:
            ways.rd_en = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* design/dcache_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

interface way_port_if #(
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
);
   import dcache_pkg::*;

   localparam int TAG_W = ADDR_W - P_SETS - OFFS_W;
   localparam int NWAYS = 1 << P_WAYS;

   logic [P_SETS-1:0] index;
   logic              rd_en;
   beat_t             rd_offs;
   logic [TAG_W-1:0]  lookup_tag;
   logic [NWAYS-1:0]  wr_way;
   beat_t             wr_offs;
   wmask_t            wr_mask;
   word_t             wr_data;
   logic              tag_we;
   logic              valid_clr;
   logic              dirty_we;
   logic              dirty_val;

   // Valid one cycle after rd_en
   logic [NWAYS-1:0]  hit_vec;
   word_t             rdata;
   logic [NWAYS-1:0]  victim_way;
   logic              victim_dirty;
   logic [TAG_W-1:0]  victim_tag;

   modport ctrl (
      output index, rd_en, rd_offs, lookup_tag, wr_way, wr_offs, wr_mask, wr_data,
      output tag_we, valid_clr, dirty_we, dirty_val,
      input  hit_vec, rdata, victim_way, victim_dirty, victim_tag
   );

   modport ways (
      input  index, rd_en, rd_offs, lookup_tag, wr_way, wr_offs, wr_mask, wr_data,
      input  tag_we, valid_clr, dirty_we, dirty_val,
      output hit_vec, rdata, victim_way, victim_dirty, victim_tag
   );

endinterface

interface line_xfer_if;
   import dcache_pkg::*;

   logic  rd_start;
   logic  wr_start;
   addr_t line_addr;
   word_t wbeat_data;
   logic  rbeat_valid;
   word_t rbeat_data;
   logic  wbeat_take;
   logic  done;

   modport ctrl (
      output rd_start, wr_start, line_addr, wbeat_data,
      input  rbeat_valid, rbeat_data, wbeat_take, done
   );

   modport master (
      input  rd_start, wr_start, line_addr, wbeat_data,
      output rbeat_valid, rbeat_data, wbeat_take, done
   );

endinterface

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   // Physical address and data path
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // Line geometry
   localparam int LINE_WORDS = 4;
   localparam int OFFS_W = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // All zero means a read
   typedef logic [WORD_W/8-1:0] wmask_t;

   // Word inside a line, also the burst beat number
   typedef logic [$clog2(LINE_WORDS)-1:0] beat_t;

   typedef enum logic [2:0]
   {
      BOOT,
      IDLE,
      REPLACE,
      WRITEBACK,
      REFILL,
      RELOAD,
      INVALIDATE
   } ctrl_state_e;

endpackage

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
)
(
   input  logic               i_clk,
   input  logic               i_rst_n,
   // Core side
   input  logic               i_req,
   input  dcache_pkg::addr_t  i_addr,
   input  dcache_pkg::wmask_t i_wmask,
   input  dcache_pkg::word_t  i_wdata,
   input  logic               i_inv,
   output logic               o_stall,
   output dcache_pkg::word_t  o_rdata,
   // AXI read
   output logic               o_arvalid,
   input  logic               i_arready,
   output dcache_pkg::addr_t  o_araddr,
   input  logic               i_rvalid,
   output logic               o_rready,
   input  dcache_pkg::word_t  i_rdata,
   input  logic               i_rlast,
   // AXI write
   output logic               o_awvalid,
   input  logic               i_awready,
   output dcache_pkg::addr_t  o_awaddr,
   output logic               o_wvalid,
   input  logic               i_wready,
   output dcache_pkg::word_t  o_wdata,
   output logic               o_wlast,
   input  logic               i_bvalid,
   output logic               o_bready
);

   way_port_if #(.P_SETS(P_SETS), .P_WAYS(P_WAYS)) u_way_port ();
   line_xfer_if u_line_xfer ();

   cache_ways #(
      .P_SETS (P_SETS),
      .P_WAYS (P_WAYS)
   )
   u_ways
   (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .port    (u_way_port.ways)
   );

   axi_line_master u_master
   (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .xfer      (u_line_xfer.master),
      .o_arvalid (o_arvalid),
      .i_arready (i_arready),
      .o_araddr  (o_araddr),
      .i_rvalid  (i_rvalid),
      .o_rready  (o_rready),
      .i_rdata   (i_rdata),
      .i_rlast   (i_rlast),
      .o_awvalid (o_awvalid),
      .i_awready (i_awready),
      .o_awaddr  (o_awaddr),
      .o_wvalid  (o_wvalid),
      .i_wready  (i_wready),
      .o_wdata   (o_wdata),
      .o_wlast   (o_wlast),
      .i_bvalid  (i_bvalid),
      .o_bready  (o_bready)
   );

   dcache_ctrl #(
      .P_SETS (P_SETS),
      .P_WAYS (P_WAYS)
   )
   u_ctrl
   (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_req   (i_req),
      .i_addr  (i_addr),
      .i_wmask (i_wmask),
      .i_wdata (i_wdata),
      .i_inv   (i_inv),
      .o_stall (o_stall),
      .o_rdata (o_rdata),
      .ways    (u_way_port.ctrl),
      .xfer    (u_line_xfer.ctrl)
   );

endmodule

`default_nettype wire

/* filelist.f */
design/dcache_pkg.sv
design/dcache_ifs.sv
design/cache_ways.sv
design/axi_line_master.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/axi_mem_model.sv
bench/dcache_chk.sv
bench/tb_dcache.sv
